/* gyro_loop_top.f */
hw/gyro_pkg.sv
hw/mod_gen.sv
hw/loop_channel.sv
hw/dac_pack.sv
hw/gyro_loop_top.sv
bench/tb_clock_gen.sv
bench/gyro_loop_tb.sv

/* bench/gyro_loop_tb.sv */
`timescale 1ns/1ps

module gyro_loop_tb;

	localparam int NUM_CH    = 3;
	localparam int WAIT_CNT  = 4;
	localparam int AVG_LOG2  = 3;
	// cycles from a trigger to the end of that half's window
	localparam int ERR_DELAY = WAIT_CNT + (1 << AVG_LOG2) + 1;
	localparam int NUM_RUNS  = 5;
	localparam int STROBES   = 6;

	logic              CLOCK_DAC_1;
	logic              i_rst;
	gyro_pkg::adc_t    adc [NUM_CH];
	logic [NUM_CH-1:0] polarity;
	logic [NUM_CH-1:0] fb_on;
	gyro_pkg::word_t   freq_cnt;
	gyro_pkg::dac_t    amp_h;
	gyro_pkg::dac_t    amp_l;
	gyro_pkg::gain_t   gain;
	gyro_pkg::word_t   const_step;
	logic              status;
	logic [NUM_CH-1:0] err_valid;
	gyro_pkg::word_t   err [NUM_CH];
	gyro_pkg::word_t   step [NUM_CH];
	gyro_pkg::dac_t    dac [NUM_CH];

	// reference model state
	int              m_edge;
	int              m_next_toggle;
	int              m_timer;
	logic            m_status;
	logic            m_trig;
	logic            m_win_hi;
	logic            m_pend;
	logic            m_err_valid;
	gyro_pkg::dac_t  m_mod;
	gyro_pkg::adc_t  m_sample [NUM_CH];
	gyro_pkg::adc_t  m_hi_sample [NUM_CH];
	gyro_pkg::word_t m_err [NUM_CH];
	gyro_pkg::word_t m_step [NUM_CH];
	gyro_pkg::word_t m_ramp [NUM_CH];
	gyro_pkg::dac_t  m_dac [NUM_CH];

	tb_clock_gen u_clk_gen (
		.CLOCK_DAC_1 (CLOCK_DAC_1),
		.o_rst       (i_rst)
	);

	gyro_loop_top #(
		.NUM_CH   (NUM_CH),
		.WAIT_CNT (WAIT_CNT),
		.AVG_LOG2 (AVG_LOG2)
	) u_dut (
		.CLOCK_DAC_1  (CLOCK_DAC_1),
		.i_rst        (i_rst),
		.i_adc        (adc),
		.i_polarity   (polarity),
		.i_fb_on      (fb_on),
		.i_freq_cnt   (freq_cnt),
		.i_amp_h      (amp_h),
		.i_amp_l      (amp_l),
		.i_gain       (gain),
		.i_const_step (const_step),
		.o_status     (status),
		.o_err_valid  (err_valid),
		.o_err        (err),
		.o_step       (step),
		.o_dac        (dac)
	);

	task abort_run;
		$display("TEST RESULT: FAIL");
		$fatal(1, "stopped at first failure");
	endtask

	task check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("error: time %0t signal %s expected %b actual %b", $time, name, exp, act);
			abort_run();
		end
	endtask

	task check_word(input string name, input gyro_pkg::word_t exp, input gyro_pkg::word_t act);
		if (act !== exp) begin
			$display("error: time %0t signal %s expected %0d actual %0d", $time, name, exp, act);
			abort_run();
		end
	endtask

	task check_dac(input string name, input gyro_pkg::dac_t exp, input gyro_pkg::dac_t act);
		if (act !== exp) begin
			$display("error: time %0t signal %s expected %h actual %h", $time, name, exp, act);
			abort_run();
		end
	endtask

	// settings stay fixed until the next reset
	task pick_settings;
		freq_cnt   = gyro_pkg::word_t'(20 + ($urandom % 41));
		amp_h      = gyro_pkg::dac_t'($urandom);
		amp_l      = gyro_pkg::dac_t'($urandom);
		gain       = gyro_pkg::gain_t'($urandom);
		const_step = gyro_pkg::word_t'($urandom);
		polarity   = NUM_CH'($urandom);
		fb_on      = NUM_CH'($urandom);
	endtask

	task draw_samples;
		for (int ch = 0; ch < NUM_CH; ch++) begin
			m_sample[ch] = gyro_pkg::adc_t'($urandom);
			adc[ch]      = m_sample[ch];
		end
	endtask

	task model_reset;
		// first toggle one full half after the first edge out of reset
		m_edge        = 0;
		m_next_toggle = int'(freq_cnt) + 1;
		m_timer       = 0;
		m_status      = 1'b0;
		m_trig        = 1'b0;
		m_win_hi      = 1'b0;
		m_pend        = 1'b0;
		m_err_valid   = 1'b0;
		m_mod         = amp_l;
		for (int ch = 0; ch < NUM_CH; ch++) begin
			m_err[ch]  = '0;
			m_step[ch] = '0;
			m_ramp[ch] = '0;
			m_dac[ch]  = '0;
		end
	endtask

	// one rising edge of the loop
	// all updates use pre-edge values
	task model_step;
		gyro_pkg::dac_t  ramp_hi;
		gyro_pkg::word_t err_v;
		for (int ch = 0; ch < NUM_CH; ch++) begin
			ramp_hi    = m_ramp[ch][31 -: gyro_pkg::DAC_W];
			m_dac[ch]  = ramp_hi + m_mod;
			// step and ramp follow the strobe by one cycle
			if (m_err_valid) begin
				m_step[ch] = fb_on[ch] ? (m_step[ch] + (m_err[ch] >>> gain)) : const_step;
				m_ramp[ch] = m_ramp[ch] + m_step[ch];
			end
		end
		m_err_valid = 1'b0;
		// end of a half's window
		if (m_timer > 0) begin
			m_timer = m_timer - 1;
			if (m_timer == 0 && m_win_hi) begin
				m_pend = 1'b1;
				for (int ch = 0; ch < NUM_CH; ch++) begin
					m_hi_sample[ch] = m_sample[ch];
				end
			end else if (m_timer == 0 && m_pend) begin
				m_pend      = 1'b0;
				m_err_valid = 1'b1;
				for (int ch = 0; ch < NUM_CH; ch++) begin
					err_v     = gyro_pkg::word_t'(m_hi_sample[ch])
						- gyro_pkg::word_t'(m_sample[ch]);
					m_err[ch] = polarity[ch] ? -err_v : err_v;
				end
			end
		end
		// half timing
		m_edge = m_edge + 1;
		m_trig = 1'b0;
		if (m_edge == m_next_toggle) begin
			m_next_toggle = m_next_toggle + int'(freq_cnt);
			m_status      = ~m_status;
			m_trig        = 1'b1;
			m_win_hi      = m_status;
			m_timer       = ERR_DELAY;
		end
		m_mod = m_status ? amp_h : amp_l;
	endtask

	task compare_outputs;
		check_bit("o_status", m_status, status);
		for (int ch = 0; ch < NUM_CH; ch++) begin
			check_bit($sformatf("o_err_valid[%0d]", ch), m_err_valid, err_valid[ch]);
			check_word($sformatf("o_err[%0d]", ch), m_err[ch], err[ch]);
			check_word($sformatf("o_step[%0d]", ch), m_step[ch], step[ch]);
			check_dac($sformatf("o_dac[%0d]", ch), m_dac[ch], dac[ch]);
		end
	endtask

	// outputs are stable at the falling edge
	// new inputs go out here too
	task run_cycle;
		@(negedge CLOCK_DAC_1);
		model_step();
		compare_outputs();
		// one constant sample per half
		if (m_trig) begin
			draw_samples();
		end
	endtask

	task wait_err_strobe;
		int waited;
		waited = 0;
		do begin
			if (waited >= 4 * int'(freq_cnt)) begin
				$display("the error strobe never arrived within four half periods");
				abort_run();
			end
			run_cycle();
			waited = waited + 1;
		end while (err_valid[0] !== 1'b1);
	endtask

	initial begin
		for (int ch = 0; ch < NUM_CH; ch++) begin
			adc[ch] = '0;
		end
		polarity   = '0;
		fb_on      = '0;
		freq_cnt   = 32'sd20;
		amp_h      = '0;
		amp_l      = '0;
		gain       = '0;
		const_step = '0;
		void'($urandom(89443));
		for (int run = 0; run < NUM_RUNS; run++) begin
			@(negedge CLOCK_DAC_1);
			pick_settings();
			u_clk_gen.apply_reset();
			model_reset();
			// all outputs cleared by reset
			compare_outputs();
			draw_samples();
			for (int n = 0; n < STROBES; n++) begin
				wait_err_strobe();
			end
			// last step has to reach the ramp and the dac words
			repeat (3) run_cycle();
		end
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

/* bench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
	output logic CLOCK_DAC_1,
	output logic o_rst
);
	// 10 ns period, first rising edge at 5 ns
	initial begin
		CLOCK_DAC_1 = 1'b0;
		forever begin
			#5 CLOCK_DAC_1 = ~CLOCK_DAC_1;
		end
	end

	// design comes up in reset
	initial begin
		o_rst = 1'b1;
	end

	// called on a falling edge, ten rising edges in reset, released on a falling edge
	task apply_reset;
		o_rst = 1'b1;
		repeat (10) @(posedge CLOCK_DAC_1);
		@(negedge CLOCK_DAC_1);
		o_rst = 1'b0;
	endtask

endmodule

/* hw/gyro_loop_top.sv */
`timescale 1ns/1ps

module gyro_loop_top #(
	parameter int NUM_CH   = 3,
	parameter int WAIT_CNT = 4,
	parameter int AVG_LOG2 = 3
) (
	input  logic            CLOCK_DAC_1,
	input  logic            i_rst,
	input  gyro_pkg::adc_t  i_adc [NUM_CH],
	input  logic [NUM_CH-1:0] i_polarity,
	input  logic [NUM_CH-1:0] i_fb_on,
	input  gyro_pkg::word_t i_freq_cnt,
	input  gyro_pkg::dac_t  i_amp_h,
	input  gyro_pkg::dac_t  i_amp_l,
	input  gyro_pkg::gain_t i_gain,
	input  gyro_pkg::word_t i_const_step,
	output logic            o_status,
	output logic [NUM_CH-1:0] o_err_valid,
	output gyro_pkg::word_t o_err [NUM_CH],
	output gyro_pkg::word_t o_step [NUM_CH],
	output gyro_pkg::dac_t  o_dac [NUM_CH]
);
	// shared bias modulation
	logic           step_trig;
	gyro_pkg::dac_t mod_out;

	// per-channel phase ramps into the packer
	gyro_pkg::word_t ramp [NUM_CH];

	mod_gen #(
		.WAIT_CNT (WAIT_CNT),
		.AVG_LOG2 (AVG_LOG2)
	) u_mod_gen (
		.CLOCK_DAC_1 (CLOCK_DAC_1),
		.i_rst       (i_rst),
		.i_freq_cnt  (i_freq_cnt),
		.i_amp_h     (i_amp_h),
		.i_amp_l     (i_amp_l),
		.o_status    (o_status),
		.o_step_trig (step_trig),
		.o_mod_out   (mod_out)
	);

	// one closed loop per fiber channel, all on the same modulation
	for (genvar g = 0; g < NUM_CH; g++) begin : g_ch
		loop_channel #(
			.WAIT_CNT (WAIT_CNT),
			.AVG_LOG2 (AVG_LOG2)
		) u_loop_channel (
			.CLOCK_DAC_1  (CLOCK_DAC_1),
			.i_rst        (i_rst),
			.i_status     (o_status),
			.i_step_trig  (step_trig),
			.i_adc        (i_adc[g]),
			.i_polarity   (i_polarity[g]),
			.i_fb_on      (i_fb_on[g]),
			.i_gain       (i_gain),
			.i_const_step (i_const_step),
			.o_err_valid  (o_err_valid[g]),
			.o_err        (o_err[g]),
			.o_step       (o_step[g]),
			.o_ramp       (ramp[g])
		);
	end

	dac_pack #(
		.NUM_CH (NUM_CH)
	) u_dac_pack (
		.CLOCK_DAC_1 (CLOCK_DAC_1),
		.i_rst       (i_rst),
		.i_ramp      (ramp),
		.i_mod_out   (mod_out),
		.o_dac       (o_dac)
	);

endmodule

/* hw/dac_pack.sv */
`timescale 1ns/1ps

module dac_pack #(
	parameter int NUM_CH = 3
) (
	input  logic            CLOCK_DAC_1,
	input  logic            i_rst,
	input  gyro_pkg::word_t i_ramp [NUM_CH],
	input  gyro_pkg::dac_t  i_mod_out,
	output gyro_pkg::dac_t  o_dac [NUM_CH]
);
	// top bits of each ramp, the fraction below is dropped
	gyro_pkg::dac_t ramp_hi [NUM_CH];

	always_comb begin
		for (int i = 0; i < NUM_CH; i++) begin
			ramp_hi[i] = i_ramp[i][31 -: gyro_pkg::DAC_W];
		end
	end

	// serrodyne ramp plus bias modulation
	// sum wraps at 16 bits like the phase it drives
	always_ff @(posedge CLOCK_DAC_1) begin
		if (i_rst) begin
			for (int i = 0; i < NUM_CH; i++) begin
				o_dac[i] <= '0;
			end
		end else begin
			for (int i = 0; i < NUM_CH; i++) begin
				o_dac[i] <= ramp_hi[i] + i_mod_out;
			end
		end
	end

endmodule

/* hw/loop_channel.sv */
`timescale 1ns/1ps

module loop_channel #(
	parameter int WAIT_CNT = 4,
	parameter int AVG_LOG2 = 3
) (
	input  logic            CLOCK_DAC_1,
	input  logic            i_rst,
	input  logic            i_status,
	input  logic            i_step_trig,
	input  gyro_pkg::adc_t  i_adc,
	input  logic            i_polarity,
	input  logic            i_fb_on,
	input  gyro_pkg::gain_t i_gain,
	input  gyro_pkg::word_t i_const_step,
	output logic            o_err_valid,
	output gyro_pkg::word_t o_err,
	output gyro_pkg::word_t o_step,
	output gyro_pkg::word_t o_ramp
);
	localparam int AVG_N   = 1 << AVG_LOG2;
	localparam int CNT_MAX = (WAIT_CNT > AVG_N) ? WAIT_CNT : AVG_N;
	localparam int CNT_W   = $clog2(CNT_MAX + 1);

	// fsm states
	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_WAIT = 2'd1;
	localparam logic [1:0] S_ACC  = 2'd2;

	logic [1:0]       state;
	// shared by the settling wait and the sample count
	logic [CNT_W-1:0] cnt;
	// half captured at the trigger, 1 = high half
	logic             half_hi;
	// sign-extended running sum of the window
	gyro_pkg::word_t  sum;
	gyro_pkg::word_t  high_avg;
	// high average stored, waiting for its low partner
	logic             high_pend;

	gyro_pkg::word_t  sum_nxt;
	gyro_pkg::word_t  avg;
	gyro_pkg::word_t  diff;
	gyro_pkg::word_t  step_nxt;

	// last sample folds straight into the average
	assign sum_nxt = sum + gyro_pkg::word_t'(i_adc);
	assign avg     = sum_nxt >>> AVG_LOG2;
	assign diff    = high_avg - avg;

	// closed loop integrates the error, open loop holds a fixed step
	assign step_nxt = i_fb_on ? (o_step + (o_err >>> i_gain)) : i_const_step;

	always_ff @(posedge CLOCK_DAC_1) begin
		if (i_rst) begin
			state       <= S_IDLE;
			cnt         <= '0;
			half_hi     <= 1'b0;
			high_pend   <= 1'b0;
			o_err_valid <= 1'b0;
			o_err       <= '0;
		end else begin
			o_err_valid <= 1'b0;
			case (state)
				S_IDLE: begin
					if (i_step_trig) begin
						state   <= S_WAIT;
						cnt     <= '0;
						half_hi <= i_status;
					end
				end
				S_WAIT: begin
					// let the fiber settle after the bias edge
					if (cnt == CNT_W'(WAIT_CNT - 1)) begin
						state <= S_ACC;
						cnt   <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				S_ACC: begin
					if (cnt == CNT_W'(AVG_N - 1)) begin
						state <= S_IDLE;
						cnt   <= '0;
						if (half_hi) begin
							high_pend <= 1'b1;
						end else if (high_pend) begin
							// error only once a full high/low pair exists
							high_pend   <= 1'b0;
							o_err_valid <= 1'b1;
							o_err       <= i_polarity ? -diff : diff;
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	// window sum and stored high average
	always_ff @(posedge CLOCK_DAC_1) begin
		if (state == S_WAIT) begin
			sum <= '0;
		end else if (state == S_ACC) begin
			sum <= sum_nxt;
		end
		if (state == S_ACC && cnt == CNT_W'(AVG_N - 1) && half_hi) begin
			high_avg <= avg;
		end
	end

	// step and ramp move one cycle after the error strobe
	always_ff @(posedge CLOCK_DAC_1) begin
		if (i_rst) begin
			o_step <= '0;
			o_ramp <= '0;
		end else if (o_err_valid) begin
			o_step <= step_nxt;
			// ramp wraps at 32 bits, that is the 2pi reset
			o_ramp <= o_ramp + step_nxt;
		end
	end

	// the half period must leave room for the full window
	a_trig_idle : assert property (
		@(posedge CLOCK_DAC_1) disable iff (i_rst)
		i_step_trig |-> (state == S_IDLE)
	) else $error("modulation edge arrived during wait or accumulate");

	a_err_pulse : assert property (
		@(posedge CLOCK_DAC_1) disable iff (i_rst)
		o_err_valid |=> !o_err_valid
	) else $error("error strobe longer than one cycle");

endmodule

/* hw/mod_gen.sv */
`timescale 1ns/1ps

module mod_gen #(
	parameter int WAIT_CNT = 4,
	parameter int AVG_LOG2 = 3
) (
	input  logic            CLOCK_DAC_1,
	input  logic            i_rst,
	input  gyro_pkg::word_t i_freq_cnt,
	input  gyro_pkg::dac_t  i_amp_h,
	input  gyro_pkg::dac_t  i_amp_l,
	output logic            o_status,
	output logic            o_step_trig,
	output gyro_pkg::dac_t  o_mod_out
);
	// cycles spent in the current half, runs 1..i_freq_cnt
	// starts at 0 out of reset so the first half is a full period too
	gyro_pkg::word_t half_cnt;
	logic            half_end;

	assign half_end = (half_cnt == i_freq_cnt);

	always_ff @(posedge CLOCK_DAC_1) begin
		if (i_rst) begin
			half_cnt    <= '0;
			o_status    <= 1'b0;
			o_step_trig <= 1'b0;
		end else begin
			// trigger lands in the same cycle as the new half
			o_step_trig <= half_end;
			if (half_end) begin
				half_cnt <= 32'sd1;
				o_status <= ~o_status;
			end else begin
				half_cnt <= half_cnt + 32'sd1;
			end
		end
	end

	// amplitude follows the half directly
	assign o_mod_out = o_status ? i_amp_h : i_amp_l;

	// every channel must finish wait + average + error before the next edge
	a_freq_window : assert property (
		@(posedge CLOCK_DAC_1) disable iff (i_rst)
		i_freq_cnt > gyro_pkg::word_t'(WAIT_CNT + (1 << AVG_LOG2) + 1)
	) else $error("half period too short for the channel window");

endmodule

/* hw/gyro_pkg.sv */
package gyro_pkg;

	// adc sample width, two's complement from the converter
	localparam int ADC_W = 14;

	// dac word width
	localparam int DAC_W = 16;

	// feedback gain is a right shift of 0..15
	localparam int GAIN_W = 4;

	// one signed adc sample
	typedef logic signed [ADC_W-1:0] adc_t;

	// dac word or modulation amplitude
	// amplitudes are signed, dac words simply wrap
	typedef logic signed [DAC_W-1:0] dac_t;

	// loop word for error, step, ramp and half-period count
	typedef logic signed [31:0] word_t;

	// gain shift amount
	typedef logic [GAIN_W-1:0] gain_t;

endpackage
